// ==== list.f ====
+incdir+.
fifo_pkg.sv
fifo_ctrl.sv
fifo_ptrs.sv
fifo_ram.sv
sync_fifo.sv
sync_fifo_tb.sv

// ==== Makefile ====
# Verilator build for the synchronous FIFO

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wall --timescale 1ns/1ps
TOP       ?= sync_fifo_tb
FILE_LIST ?= list.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

# the simulator exits non-zero on any fatal, so make fails with it
test: $(SIM_BIN)
	./$(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(shell sed -n '/^[^+]/p' $(FILE_LIST)) fifo_cfg.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sync_fifo_tb.sv ====
`default_nettype none

`include "fifo_cfg.svh"

module sync_fifo_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import fifo_pkg::*;

   localparam int          DEPTH         = 1 << `FIFO_ADDR_W;
   localparam int          DRIVE_DELAY   = 10;
   localparam int          SAMPLE_DELAY  = 5;
   localparam int          RESET_TIMEOUT = 8;
   localparam logic [31:0] LFSR_SEED     = 32'hb64e79bd;
   // x^32 + x^22 + x^2 + x + 1 in right-shift form
   localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

   // one step of the table
   // expected status only used when spelled is set
   typedef struct packed {
      logic        we;
      logic        re;
      logic        spelled;
      fifo_count_t occ;
      logic        full;
      logic        empty;
   } row_t;

   logic        clk;
   logic        rst;
   logic        write_en;
   fifo_data_t  w_data;
   logic        read_en;
   fifo_data_t  r_data;
   logic        full;
   logic        empty;
   fifo_count_t occupancy;

   row_t        rows[$];
   fifo_data_t  model_q[$];
   fifo_data_t  exp_rdata;
   logic [31:0] lfsr_state;

   sync_fifo i_dut (
      .clk       (clk),
      .rst       (rst),
      .write_en  (write_en),
      .w_data    (w_data),
      .read_en   (read_en),
      .r_data    (r_data),
      .full      (full),
      .empty     (empty),
      .occupancy (occupancy)
   );

   always #50 clk = ~clk;

   // reset held for two rising edges
   initial begin
      clk = 1'b0;
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_TAPS;
      end
      return s >> 1;
   endfunction

   // one LFSR step per data bit
   // first bit taken ends up in bit 0
   task automatic draw_word(output fifo_data_t word);
      word = '0;
      repeat (`FIFO_DATA_W) begin
         word       = {lfsr_state[0], word[`FIFO_DATA_W-1:1]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic check_data(input string name, input fifo_data_t exp, input fifo_data_t act);
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
         $display("Testbench failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_count(input string name, input fifo_count_t exp,
                              input fifo_count_t act);
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
         $display("Testbench failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %0b, actual %0b", $time, name, exp, act);
         $display("Testbench failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic add_row(input int wr, input int rd, input int spelled,
                          input int occ, input int fl, input int em);
      row_t r;
      r.we      = (wr != 0);
      r.re      = (rd != 0);
      r.spelled = (spelled != 0);
      r.occ     = fifo_count_t'(occ);
      r.full    = (fl != 0);
      r.empty   = (em != 0);
      rows.push_back(r);
   endtask

   // columns are write_en, read_en, spelled, occupancy, full and empty
   task automatic build_table();
      // fill to full
      // empty falls after the first write
      add_row(1, 0, 1,  1, 0, 0);
      add_row(1, 0, 1,  2, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 1,  8, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 0,  0, 0, 0);
      add_row(1, 0, 1, 15, 0, 0);
      add_row(1, 0, 1, 16, 1, 0);
      // write while full is dropped
      add_row(1, 0, 1, 16, 1, 0);
      // both on a full buffer take only the read
      add_row(1, 1, 1, 15, 0, 0);
      // both on a partly filled buffer
      add_row(1, 1, 1, 15, 0, 0);
      add_row(1, 1, 1, 15, 0, 0);
      // drain in order
      add_row(0, 1, 1, 14, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 1,  7, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 0,  0, 0, 0);
      add_row(0, 1, 1,  1, 0, 0);
      add_row(0, 1, 1,  0, 0, 1);
      // read while empty changes nothing
      add_row(0, 1, 1,  0, 0, 1);
      // both on an empty buffer take only the write
      add_row(1, 1, 1,  1, 0, 0);
      add_row(0, 1, 1,  0, 0, 1);
      add_row(1, 0, 1,  1, 0, 0);
      add_row(0, 1, 1,  0, 0, 1);
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (rst !== 1'b0 || empty !== 1'b1) begin
         if (cycles == RESET_TIMEOUT) begin
            $display("reset never ended within %0d cycles", RESET_TIMEOUT);
            $display("Testbench failed");
            $fatal(1, "reset timeout");
         end
         @(posedge clk);
         cycles++;
      end
   endtask

   initial begin
      row_t       r;
      fifo_data_t word;
      logic       wr_ok;
      logic       rd_ok;

      write_en   = 1'b0;
      read_en    = 1'b0;
      w_data     = '0;
      exp_rdata  = '0;
      lfsr_state = LFSR_SEED;
      build_table();

      wait_reset_release();
      #DRIVE_DELAY;
      check_count("occupancy", '0, occupancy);
      check_flag("empty", 1'b1, empty);
      check_flag("full", 1'b0, full);
      check_data("r_data", '0, r_data);

      for (int i = 0; i < rows.size(); i++) begin
         r = rows[i];
         draw_word(word);
         w_data   = word;
         write_en = r.we;
         read_en  = r.re;

         // model acceptance from the count before the edge
         wr_ok = r.we && (model_q.size() < DEPTH);
         rd_ok = r.re && (model_q.size() > 0);
         if (rd_ok) begin
            exp_rdata = model_q.pop_front();
         end
         if (wr_ok) begin
            model_q.push_back(word);
         end

         @(posedge clk);
         #SAMPLE_DELAY;
         check_data("r_data", exp_rdata, r_data);
         check_count("occupancy", fifo_count_t'(model_q.size()), occupancy);
         check_flag("full", (model_q.size() == DEPTH), full);
         check_flag("empty", (model_q.size() == 0), empty);
         if (r.spelled) begin
            check_count("occupancy", r.occ, occupancy);
            check_flag("full", r.full, full);
            check_flag("empty", r.empty, empty);
         end
         #(DRIVE_DELAY - SAMPLE_DELAY);
      end

      write_en = 1'b0;
      read_en  = 1'b0;
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
`default_nettype none

module sync_fifo (
   input  wire logic                 clk,
   input  wire logic                 rst,
   // write side
   input  wire logic                 write_en,
   input  wire fifo_pkg::fifo_data_t w_data,
   // read side
   input  wire logic                 read_en,
   output fifo_pkg::fifo_data_t      r_data,
   // status, all registered
   output logic                      full,
   output logic                      empty,
   output fifo_pkg::fifo_count_t     occupancy
);

   import fifo_pkg::*;

   // gated strobes from the control block
   logic       wr_accept;
   logic       rd_accept;

   // ring pointers into the array
   fifo_addr_t wr_addr;
   fifo_addr_t rd_addr;

   // flags, occupancy and strobe gating
   fifo_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .write_en  (write_en),
      .read_en   (read_en),
      .wr_accept (wr_accept),
      .rd_accept (rd_accept),
      .full      (full),
      .empty     (empty),
      .occupancy (occupancy)
   );

   fifo_ptrs u_ptrs (
      .clk       (clk),
      .rst       (rst),
      .wr_accept (wr_accept),
      .rd_accept (rd_accept),
      .wr_addr   (wr_addr),
      .rd_addr   (rd_addr)
   );

   // write data goes straight in, read data straight out
   fifo_ram u_ram (
      .clk       (clk),
      .rst       (rst),
      .wr_accept (wr_accept),
      .wr_addr   (wr_addr),
      .w_data    (w_data),
      .rd_accept (rd_accept),
      .rd_addr   (rd_addr),
      .r_data    (r_data)
   );

endmodule

`default_nettype wire

// ==== fifo_ram.sv ====
`default_nettype none

`include "fifo_cfg.svh"

module fifo_ram (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic                 wr_accept,
   input  wire fifo_pkg::fifo_addr_t wr_addr,
   input  wire fifo_pkg::fifo_data_t w_data,
   input  wire logic                 rd_accept,
   input  wire fifo_pkg::fifo_addr_t rd_addr,
   output fifo_pkg::fifo_data_t      r_data
);

   import fifo_pkg::*;

   localparam int DEPTH = 1 << `FIFO_ADDR_W;

   // storage array
   fifo_data_t mem [DEPTH];

   // write port, lands at the accepting edge
   always_ff @(posedge clk) begin
      if (wr_accept) begin
         mem[wr_addr] <= w_data;
      end
   end

   // registered read port
   // holds its word until the next accepted read
   // read and write never hit one address at one edge: that needs
   // an empty or a full buffer, and then one strobe is blocked
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         r_data <= '0;
      end else if (rd_accept) begin
         r_data <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

// ==== fifo_ptrs.sv ====
`default_nettype none

module fifo_ptrs (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           wr_accept,
   input  wire logic           rd_accept,
   output fifo_pkg::fifo_addr_t wr_addr,
   output fifo_pkg::fifo_addr_t rd_addr
);

   import fifo_pkg::*;

   localparam fifo_addr_t ADDR_STEP = fifo_addr_t'(1);

   fifo_addr_t wr_addr_next;
   fifo_addr_t rd_addr_next;

   // pointer width matches the array, so the sum wraps at the depth
   assign wr_addr_next = wr_addr + ADDR_STEP;
   assign rd_addr_next = rd_addr + ADDR_STEP;

   // write side of the ring
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_addr <= '0;
      end else if (wr_accept) begin
         wr_addr <= wr_addr_next;
      end
   end

   // read side of the ring
   // points at the oldest stored word while the buffer is not empty
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr <= '0;
      end else if (rd_accept) begin
         rd_addr <= rd_addr_next;
      end
   end

endmodule

`default_nettype wire

// ==== fifo_ctrl.sv ====
`default_nettype none

`include "fifo_cfg.svh"

module fifo_ctrl (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            write_en,
   input  wire logic            read_en,
   output logic                 wr_accept,
   output logic                 rd_accept,
   output logic                 full,
   output logic                 empty,
   output fifo_pkg::fifo_count_t occupancy
);

   import fifo_pkg::*;

   // count values where a flag changes
   localparam fifo_count_t CNT_ONE  = fifo_count_t'(1);
   localparam fifo_count_t CNT_LAST = fifo_count_t'((1 << `FIFO_ADDR_W) - 1);

   logic        lone_write;
   logic        lone_read;
   fifo_count_t occ_next;
   logic        full_next;
   logic        empty_next;

   // the only place where the flags gate the strobes
   // everything downstream trusts these two
   assign wr_accept = write_en & ~full;
   assign rd_accept = read_en & ~empty;

   // a read and a write together leave the count alone
   assign lone_write = wr_accept & ~rd_accept;
   assign lone_read  = rd_accept & ~wr_accept;

   always_comb begin
      occ_next   = occupancy;
      full_next  = full;
      empty_next = empty;
      if (lone_write) begin
         occ_next   = occupancy + CNT_ONE;
         // last free slot about to be taken
         full_next  = (occupancy == CNT_LAST);
         empty_next = 1'b0;
      end else if (lone_read) begin
         occ_next   = occupancy - CNT_ONE;
         // last stored word about to leave
         empty_next = (occupancy == CNT_ONE);
         full_next  = 1'b0;
      end
   end

   // flags are held in registers, not decoded from the count
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         occupancy <= '0;
         full      <= 1'b0;
         empty     <= 1'b1;
      end else begin
         occupancy <= occ_next;
         full      <= full_next;
         empty     <= empty_next;
      end
   end

endmodule

`default_nettype wire

// ==== fifo_pkg.sv ====
`default_nettype none

`include "fifo_cfg.svh"

package fifo_pkg;

   // one data word as written and read
   typedef logic [`FIFO_DATA_W-1:0] fifo_data_t;

   // one location in the storage array
   typedef logic [`FIFO_ADDR_W-1:0] fifo_addr_t;

   // stored entries, zero to depth inclusive
   // one extra bit so a full buffer is representable
   typedef logic [`FIFO_ADDR_W:0] fifo_count_t;

endpackage

`default_nettype wire

// ==== fifo_cfg.svh ====
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// width of one stored data word
`define FIFO_DATA_W 8

// address width of the storage array
// depth is two to this power, 16 entries
`define FIFO_ADDR_W 4

`endif
